// File: verilog.f
+incdir+src
src/core_glue_pkg.sv
src/reset_sequencer.sv
src/dataslot_bridge.sv
src/video_out.sv
src/core_glue_top.sv
verif/tb_clock_gen.sv
verif/core_glue_props.sv
verif/core_glue_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core glue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module core_glue_tb \
  -o core_glue_sim

./obj_dir/core_glue_sim 2>&1 | tee sim.log

# a run that stops early never reaches the pass line
if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi

echo "simulation passed"
exit 0

// File: verif/core_glue_tb.sv
/*
 * core glue testbench
 * random read mux, video, stretcher, table lookup, completion
 * and core reset stimulus, checked against a timing model
 */

`timescale 1ns/10ps

`include "core_glue_settings.svh"

module core_glue_tb;

  localparam int SYNC        = `CORE_SYNC_STAGES;
  localparam int STRETCH     = `CORE_READ_STRETCH;
  localparam int HOLD_CYCLES = (1 << `CORE_RESET_TIMER_W) - 1;
  // per test cycle counts where the two full holds dominate
  localparam int TEST_CYCLES = 200 + 301 + 13 * 46 + 66 + 16 * 14 + 2 * HOLD_CYCLES + 200;
  localparam int WATCHDOG_NS = TEST_CYCLES * 8 * 6 / 5;

  logic clk_sys;
  logic rst_n;
  logic start_button;
  logic select_button;
  logic host_running;
  logic write_request;
  logic all_complete;
  logic core_reset;
  logic downloading;
  logic select_held;
  logic slot_done;
  logic complete_pulse;
  core_glue_pkg::bridge_addr_t bridge_addr;
  core_glue_pkg::bridge_data_t cmd_rd_data;
  core_glue_pkg::bridge_data_t bridge_rd_data;
  core_glue_pkg::slot_read_t   read_req;
  core_glue_pkg::slot_read_t   slot_read;
  core_glue_pkg::file_size_t   table_q;
  core_glue_pkg::file_size_t   file_size;
  core_glue_pkg::table_addr_t  table_addr;
  core_glue_pkg::video_in_t    video_in;
  core_glue_pkg::video_out_t   video;

  logic [31:0] rng_state = 32'h4061e4f0;

  tb_clock_gen i_tb_clock_gen (.clk_sys(clk_sys), .rst_n(rst_n));

  core_glue_top i_core_glue_top (.*);

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] rand32();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // upper half only since the low lcg bits are weak
  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = rand32();
    return int'(r[31:16]) % n;
  endfunction

  // top bits repeated into the low end of each channel
  function automatic core_glue_pkg::rgb888_t expand_rgb565(input core_glue_pkg::rgb565_t p);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    r = (8'(p[15:11]) << 3) | 8'(p[15:11] >> 2);
    g = (8'(p[10:5]) << 2) | 8'(p[10:5] >> 4);
    b = (8'(p[4:0]) << 3) | 8'(p[4:0] >> 2);
    return {r, g, b};
  endfunction

  function automatic core_glue_pkg::table_addr_t slot_table_addr(
    input core_glue_pkg::slot_id_t id);
    return core_glue_pkg::table_addr_t'(2 * int'(id[`CORE_TABLE_ADDR_W-1:0]) + 1);
  endfunction

  // every address bit shows up in the table contents
  function automatic core_glue_pkg::file_size_t table_fill(input core_glue_pkg::table_addr_t a);
    return {a, 6'h2a, ~a, 6'h15};
  endfunction

  task automatic tick();
    @(posedge clk_sys);
    #1;
  endtask

  task automatic report_failure();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic read_mux_sweep();
    logic [31:0] r;
    logic [31:0] exp;
    int n;
    for (n = 0; n < 200; n++) begin
      r = rand32();
      bridge_addr = rand32();
      // about half of the reads hit the command region
      if (r[31]) begin
        bridge_addr[31:24] = `CORE_CMD_REGION;
      end else if (bridge_addr[31:24] == `CORE_CMD_REGION) begin
        // misses stay outside the region
        bridge_addr[31:24] = ~bridge_addr[31:24];
      end
      cmd_rd_data = rand32();
      #1;
      exp = r[31] ? cmd_rd_data : '0;
      compare_word("bridge_rd_data", bridge_rd_data, exp);
      tick();
    end
  endtask

  task automatic video_sweep();
    logic [31:0] r;
    core_glue_pkg::video_in_t vin;
    core_glue_pkg::video_in_t prev_vin;
    core_glue_pkg::rgb888_t   exp_pixel;
    int n;
    prev_vin  = '0;
    exp_pixel = '0;
    for (n = 0; n <= 300; n++) begin
      r = rand32();
      vin = r[31:13];
      video_in = vin;
      // output still shows the pixel registered at the last edge
      #1;
      compare_word("video.de", 32'(video.de), 32'(prev_vin.de));
      compare_word("video.hs", 32'(video.hs), 32'(prev_vin.hs));
      compare_word("video.vs", 32'(video.vs), 32'(prev_vin.vs));
      compare_word("video.pixel", 32'(video.pixel), 32'(exp_pixel));
      prev_vin  = vin;
      exp_pixel = vin.de ? expand_rgb565(vin.pixel) : '0;
      tick();
    end
    video_in = '0;
    tick();
  endtask

  task automatic stretcher_sweep();
    core_glue_pkg::slot_read_t req;
    int high_len;
    int gap;
    int n;
    int k;
    for (n = 0; n < 13; n++) begin
      req.read        = 1'b1;
      req.data_offset = rand32();
      req.length      = rand32();
      req.slot_id     = 16'(rand32());
      // last request stays high well past the strobe
      high_len = (n == 12) ? 30 : 1 + rand_below(4);
      gap      = 8 + rand_below(5);
      read_req = req;
      for (k = 1; k <= high_len + gap; k++) begin
        tick();
        compare_word("slot_read.read", 32'(slot_read.read), 32'(k <= STRETCH));
        if (k == 1) begin
          // new field values must not reach the registered copy yet
          read_req.data_offset = ~req.data_offset;
          read_req.length      = ~req.length;
          read_req.slot_id     = ~req.slot_id;
          #1;
          compare_word("slot_read.data_offset", slot_read.data_offset, req.data_offset);
          compare_word("slot_read.length", slot_read.length, req.length);
          compare_word("slot_read.slot_id", 32'(slot_read.slot_id), 32'(req.slot_id));
        end
        if (k == high_len) begin
          read_req.read = 1'b0;
        end
      end
    end
  endtask

  task automatic lookup_sweep();
    core_glue_pkg::slot_id_t    id;
    core_glue_pkg::table_addr_t prev_addr;
    core_glue_pkg::file_size_t  prev_q;
    int n;
    prev_addr = '0;
    prev_q    = '0;
    for (n = 0; n <= 64; n++) begin
      id = 16'(rand32());
      read_req.slot_id = id;
      // table answers the address registered at the last edge
      table_q = table_fill(prev_addr);
      // outputs still hold what the last edge captured
      #1;
      if (n > 0) begin
        compare_word("table_addr", 32'(table_addr), 32'(prev_addr));
        compare_word("file_size", file_size, prev_q);
      end
      prev_addr = slot_table_addr(id);
      prev_q    = table_q;
      tick();
    end
  endtask

  task automatic completion_sweep();
    int high_len;
    int gap;
    int n;
    int k;
    for (n = 0; n < 16; n++) begin
      high_len = 1 + rand_below(4);
      gap      = 6 + rand_below(5);
      slot_done = 1'b1;
      for (k = 1; k <= high_len + gap; k++) begin
        tick();
        // synchronizer stages plus the edge register
        compare_word("complete_pulse", 32'(complete_pulse), 32'(k == SYNC + 1));
        if (k == high_len) begin
          slot_done = 1'b0;
        end
      end
    end
  endtask

  task automatic core_reset_sequence();
    int n;
    int wait_cycles;
    int high_cycles;
    tick();
    compare_word("core_reset", 32'(core_reset), 32'(1'b1));
    host_running = 1'b1;
    tick();
    compare_word("core_reset", 32'(core_reset), 32'(1'b0));
    // select through the synchronizer
    select_button = 1'b1;
    for (n = 1; n <= SYNC; n++) begin
      tick();
      compare_word("select_held", 32'(select_held), 32'(n == SYNC));
    end
    select_button = 1'b0;
    for (n = 1; n <= SYNC; n++) begin
      tick();
      compare_word("select_held", 32'(select_held), 32'(n < SYNC));
    end
    // download window
    write_request = 1'b1;
    tick();
    compare_word("downloading", 32'(downloading), 32'(1'b1));
    compare_word("core_reset", 32'(core_reset), 32'(1'b1));
    write_request = 1'b0;
    wait_cycles = 3 + rand_below(8);
    for (n = 0; n < wait_cycles; n++) begin
      tick();
      compare_word("core_reset", 32'(core_reset), 32'(1'b1));
    end
    // set wins over a clear in the same cycle
    write_request = 1'b1;
    all_complete  = 1'b1;
    tick();
    compare_word("downloading", 32'(downloading), 32'(1'b1));
    write_request = 1'b0;
    tick();
    compare_word("downloading", 32'(downloading), 32'(1'b0));
    compare_word("core_reset", 32'(core_reset), 32'(1'b0));
    all_complete = 1'b0;
    // full hold after a start press
    start_button = 1'b1;
    wait_cycles = 0;
    while (core_reset !== 1'b1 && wait_cycles <= SYNC + 1) begin
      tick();
      wait_cycles++;
    end
    assert (core_reset === 1'b1) else begin
      $display("core_reset did not rise after the start button press");
      report_failure();
    end
    start_button = 1'b0;
    high_cycles = 0;
    while (core_reset === 1'b1 && high_cycles <= HOLD_CYCLES) begin
      high_cycles++;
      tick();
    end
    compare_word("core_reset hold cycles", 32'(high_cycles), 32'(HOLD_CYCLES));
    // second press during a hold restarts the countdown
    start_button = 1'b1;
    repeat (20) tick();
    start_button = 1'b0;
    repeat (5) tick();
    start_button = 1'b1;
    high_cycles = 0;
    tick();
    while (core_reset === 1'b1 && high_cycles <= SYNC + HOLD_CYCLES) begin
      high_cycles++;
      tick();
    end
    compare_word("core_reset reload cycles", 32'(high_cycles), 32'(SYNC + HOLD_CYCLES));
    start_button = 1'b0;
    tick();
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    start_button  = 1'b0;
    select_button = 1'b0;
    host_running  = 1'b0;
    write_request = 1'b0;
    all_complete  = 1'b0;
    slot_done     = 1'b0;
    bridge_addr   = '0;
    cmd_rd_data   = '0;
    read_req      = '0;
    table_q       = '0;
    video_in      = '0;
    @(negedge rst_n);
    @(posedge rst_n);
    tick();
    compare_word("core_reset", 32'(core_reset), 32'(1'b1));
    compare_word("slot_read.read", 32'(slot_read.read), 32'(1'b0));
    compare_word("complete_pulse", 32'(complete_pulse), 32'(1'b0));
    compare_word("video", 32'(video), 32'(0));
    read_mux_sweep();
    video_sweep();
    stretcher_sweep();
    lookup_sweep();
    completion_sweep();
    core_reset_sequence();
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, tests did not finish within %0d ns", WATCHDOG_NS);
    report_failure();
  end

endmodule

// File: verif/core_glue_props.sv
/*
 * core glue timing properties
 * read strobe length, single cycle completion pulse and
 * output values at reset release, bound to the top level
 */

`timescale 1ns/10ps

`include "core_glue_settings.svh"

module core_glue_props (
  input logic                     clk_sys,
  input logic                     rst_n,
  input core_glue_pkg::slot_read_t slot_read,
  input logic                     complete_pulse,
  input logic                     core_reset,
  input core_glue_pkg::video_out_t video
);

  localparam logic [`CORE_READ_STRETCH_W:0] STRETCH_LEN =
    (`CORE_READ_STRETCH_W+1)'(`CORE_READ_STRETCH);

  // length of the current strobe, one spare bit
  logic [`CORE_READ_STRETCH_W:0] high_run;

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      high_run <= '0;
    end else if (slot_read.read) begin
      high_run <= high_run + 1'b1;
    end else begin
      high_run <= '0;
    end
  end

  //////////////////////////////////////////////////
  // read strobe
  //////////////////////////////////////////////////

  // strobe ends after exactly the stretch count
  strobe_length: assert property (@(posedge clk_sys) disable iff (!rst_n)
    $fell(slot_read.read) |-> high_run == STRETCH_LEN)
    else $error("read strobe ended after %0d cycles", high_run);

  // never longer than the stretch count
  strobe_overrun: assert property (@(posedge clk_sys) disable iff (!rst_n)
    slot_read.read |-> high_run < STRETCH_LEN)
    else $error("read strobe longer than the stretch count");

  //////////////////////////////////////////////////
  // completion and reset values
  //////////////////////////////////////////////////

  pulse_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
    complete_pulse |=> !complete_pulse)
    else $error("complete_pulse high for more than one cycle");

  // host_running is low at release, so core reset is held
  reset_values: assert property (@(posedge clk_sys)
    $rose(rst_n) |-> !slot_read.read && !complete_pulse && core_reset && (video == '0))
    else $error("outputs not at their reset values at reset release");

endmodule

bind core_glue_top core_glue_props i_core_glue_props (
  .clk_sys        (clk_sys),
  .rst_n          (rst_n),
  .slot_read      (slot_read),
  .complete_pulse (complete_pulse),
  .core_reset     (core_reset),
  .video          (video)
);

// File: verif/tb_clock_gen.sv
/*
 * testbench clock and reset
 * 8 ns clk_sys, rst_n held low for 4 cycles
 */

`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_sys,
  output logic rst_n
);

  initial begin
    clk_sys = 1'b0;
    forever #(HALF_PERIOD) clk_sys = ~clk_sys;
  end

  // falling edge just after time zero, release 1 ns after an edge
  initial begin
    rst_n = 1'b1;
    #1;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_sys);
    #1;
    rst_n = 1'b1;
  end

endmodule

// File: src/core_glue_top.sv
/*
 * core glue top level
 * wires the reset sequencer, dataslot bridge and video output
 */

`timescale 1ns/10ps

module core_glue_top (
  input  logic                       clk_sys,
  input  logic                       rst_n,
  // player controls and host state
  input  logic                       start_button,
  input  logic                       select_button,
  input  logic                       host_running,
  input  logic                       write_request,
  input  logic                       all_complete,
  output logic                       core_reset,
  output logic                       downloading,
  output logic                       select_held,
  // bridge and dataslot side
  input  core_glue_pkg::bridge_addr_t bridge_addr,
  input  core_glue_pkg::bridge_data_t cmd_rd_data,
  input  core_glue_pkg::slot_read_t   read_req,
  input  logic                       slot_done,
  input  core_glue_pkg::file_size_t   table_q,
  output core_glue_pkg::bridge_data_t bridge_rd_data,
  output core_glue_pkg::slot_read_t   slot_read,
  output core_glue_pkg::table_addr_t  table_addr,
  output core_glue_pkg::file_size_t   file_size,
  output logic                       complete_pulse,
  // video to the scaler
  input  core_glue_pkg::video_in_t    video_in,
  output core_glue_pkg::video_out_t   video
);

  // reset source for the soft system
  reset_sequencer i_reset_sequencer (
    .clk_sys       (clk_sys),
    .rst_n         (rst_n),
    .start_button  (start_button),
    .select_button (select_button),
    .host_running  (host_running),
    .write_request (write_request),
    .all_complete  (all_complete),
    .core_reset    (core_reset),
    .downloading   (downloading),
    .select_held   (select_held)
  );

  // bridge reads, dataslot requests and completion
  dataslot_bridge i_dataslot_bridge (
    .clk_sys        (clk_sys),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .cmd_rd_data    (cmd_rd_data),
    .read_req       (read_req),
    .slot_done      (slot_done),
    .table_q        (table_q),
    .bridge_rd_data (bridge_rd_data),
    .slot_read      (slot_read),
    .table_addr     (table_addr),
    .file_size      (file_size),
    .complete_pulse (complete_pulse)
  );

  // pixel path
  video_out i_video_out (
    .clk_sys  (clk_sys),
    .rst_n    (rst_n),
    .video_in (video_in),
    .video    (video)
  );

endmodule

// File: src/video_out.sv
/*
 * video output stage
 * expands rgb565 to rgb888, blanks outside display enable and
 * registers the pixel with the sync signals toward the scaler
 */

`timescale 1ns/10ps

module video_out (
  input  logic                     clk_sys,
  input  logic                     rst_n,
  input  core_glue_pkg::video_in_t  video_in,
  output core_glue_pkg::video_out_t video
);

  // channel slices of the input pixel
  logic [4:0] red5;
  logic [5:0] green6;
  logic [4:0] blue5;

  core_glue_pkg::rgb888_t pixel_exp;
  core_glue_pkg::rgb888_t pixel_blank;

  //////////////////////////////////////////////////
  // color expansion
  //////////////////////////////////////////////////

  assign red5   = video_in.pixel[15:11];
  assign green6 = video_in.pixel[10:5];
  assign blue5  = video_in.pixel[4:0];

  // repeat top bits into the low end so full scale maps to ff
  assign pixel_exp = {{red5, red5[4:2]},
                      {green6, green6[5:4]},
                      {blue5, blue5[4:2]}};

  // black outside the active area
  assign pixel_blank = video_in.de ? pixel_exp : '0;

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      video <= '0;
    end else begin
      video.de    <= video_in.de;
      video.hs    <= video_in.hs;
      video.vs    <= video_in.vs;
      video.pixel <= pixel_blank;
    end
  end

endmodule

// File: src/dataslot_bridge.sv
/*
 * dataslot bridge
 * bridge read mux for the command region, read strobe stretcher,
 * data table lookup of the file size and completion pulse
 */

`timescale 1ns/10ps

`include "core_glue_settings.svh"

module dataslot_bridge (
  input  logic                       clk_sys,
  input  logic                       rst_n,
  input  core_glue_pkg::bridge_addr_t bridge_addr,
  input  core_glue_pkg::bridge_data_t cmd_rd_data,
  input  core_glue_pkg::slot_read_t   read_req,
  input  logic                       slot_done,
  input  core_glue_pkg::file_size_t   table_q,
  output core_glue_pkg::bridge_data_t bridge_rd_data,
  output core_glue_pkg::slot_read_t   slot_read,
  output core_glue_pkg::table_addr_t  table_addr,
  output core_glue_pkg::file_size_t   file_size,
  output logic                       complete_pulse
);

  localparam logic [`CORE_READ_STRETCH_W-1:0] STRETCH_LOAD = `CORE_READ_STRETCH;

  // stretcher state
  logic                            read_prev;
  logic [`CORE_READ_STRETCH_W-1:0] stretch_cnt;
  // request fields, one cycle behind the request
  core_glue_pkg::slot_read_t       req_q;

  // completion synchronizer and edge detect
  logic [`CORE_SYNC_STAGES-1:0] done_sync;
  logic                         done_prev;

  //////////////////////////////////////////////////
  // bridge read mux
  //////////////////////////////////////////////////

  always_comb begin
    // only the command region answers, all else reads zero
    if (bridge_addr[`CORE_BRIDGE_W-1 -: 8] == `CORE_CMD_REGION) begin
      bridge_rd_data = cmd_rd_data;
    end else begin
      bridge_rd_data = '0;
    end
  end

  //////////////////////////////////////////////////
  // read strobe stretcher
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      read_prev   <= 1'b0;
      stretch_cnt <= '0;
    end else begin
      read_prev <= read_req.read;
      if (read_req.read && !read_prev) begin
        stretch_cnt <= STRETCH_LOAD;
      end else if (stretch_cnt != '0) begin
        stretch_cnt <= stretch_cnt - 1'b1;
      end
    end
  end

  // fields follow the request every cycle
  always_ff @(posedge clk_sys) begin
    req_q <= read_req;
  end

  always_comb begin
    slot_read      = req_q;
    slot_read.read = (stretch_cnt != '0);
  end

  //////////////////////////////////////////////////
  // table lookup and completion
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      table_addr     <= '0;
      file_size      <= '0;
      done_sync      <= '0;
      done_prev      <= 1'b0;
      complete_pulse <= 1'b0;
    end else begin
      // size entry of a slot sits at 2*id+1, low bit always set
      table_addr     <= {read_req.slot_id[`CORE_TABLE_ADDR_W-2:0], 1'b1};
      file_size      <= table_q;
      done_sync      <= {done_sync[`CORE_SYNC_STAGES-2:0], slot_done};
      done_prev      <= done_sync[`CORE_SYNC_STAGES-1];
      // single cycle on the synchronized rising edge
      complete_pulse <= done_sync[`CORE_SYNC_STAGES-1] & ~done_prev;
    end
  end

endmodule

// File: src/reset_sequencer.sv
/*
 * reset sequencer
 * synchronizes the select and start buttons, reloads a reset
 * countdown on each start press, keeps the download flag and
 * combines everything into a registered core reset
 */

`timescale 1ns/10ps

`include "core_glue_settings.svh"

module reset_sequencer (
  input  logic clk_sys,
  input  logic rst_n,
  input  logic start_button,
  input  logic select_button,
  input  logic host_running,
  input  logic write_request,
  input  logic all_complete,
  output logic core_reset,
  output logic downloading,
  output logic select_held
);

  // full hold length
  localparam logic [`CORE_RESET_TIMER_W-1:0] HOLD_MAX = '1;

  // button synchronizer chains, stage 0 samples the pin
  logic [`CORE_SYNC_STAGES-1:0] start_sync;
  logic [`CORE_SYNC_STAGES-1:0] select_sync;

  logic start_s;
  logic start_prev;
  logic start_rise;

  // countdown and flag, current and next
  logic [`CORE_RESET_TIMER_W-1:0] reset_timer;
  logic [`CORE_RESET_TIMER_W-1:0] reset_timer_nxt;
  logic                           download_flag;
  logic                           download_flag_nxt;

  //////////////////////////////////////////////////
  // button synchronizers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      start_sync  <= '0;
      select_sync <= '0;
      start_prev  <= 1'b0;
    end else begin
      // shift toward the msb
      start_sync  <= {start_sync[`CORE_SYNC_STAGES-2:0], start_button};
      select_sync <= {select_sync[`CORE_SYNC_STAGES-2:0], select_button};
      start_prev  <= start_s;
    end
  end

  assign start_s = start_sync[`CORE_SYNC_STAGES-1];
  // one cycle on a press
  assign start_rise = start_s & ~start_prev;

  // menu key level for the soft system
  assign select_held = select_sync[`CORE_SYNC_STAGES-1];

  //////////////////////////////////////////////////
  // countdown and download flag
  //////////////////////////////////////////////////

  always_comb begin
    reset_timer_nxt = reset_timer;
    if (start_rise) begin
      // restart the hold on every press
      reset_timer_nxt = HOLD_MAX;
    end else if (reset_timer != '0) begin
      reset_timer_nxt = reset_timer - 1'b1;
    end
  end

  always_comb begin
    download_flag_nxt = download_flag;
    // set has priority over clear
    if (write_request) begin
      download_flag_nxt = 1'b1;
    end else if (all_complete) begin
      download_flag_nxt = 1'b0;
    end
  end

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      reset_timer   <= '0;
      download_flag <= 1'b0;
      core_reset    <= 1'b1;
    end else begin
      reset_timer   <= reset_timer_nxt;
      download_flag <= download_flag_nxt;
      // built from next state so it lines up with flag and timer
      core_reset    <= ~host_running | download_flag_nxt | (reset_timer_nxt != '0);
    end
  end

  assign downloading = download_flag;

endmodule

// File: src/core_glue_pkg.sv
/*
 * core glue types
 * bridge words, dataslot fields, pixel formats and the
 * packed structs that travel between the glue blocks
 */

`include "core_glue_settings.svh"

package core_glue_pkg;

  //////////////////////////////////////////////////
  // plain vectors
  //////////////////////////////////////////////////

  typedef logic [`CORE_BRIDGE_W-1:0]     bridge_addr_t;
  typedef logic [`CORE_BRIDGE_W-1:0]     bridge_data_t;
  typedef logic [`CORE_SLOT_ID_W-1:0]    slot_id_t;
  typedef logic [`CORE_TABLE_ADDR_W-1:0] table_addr_t;
  // file size word read back from the data table
  typedef logic [`CORE_BRIDGE_W-1:0]     file_size_t;

  // 5 red, 6 green, 5 blue
  typedef logic [15:0] rgb565_t;
  // 8 bits per channel, red on top
  typedef logic [23:0] rgb888_t;

  //////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////

  // pixel stream from the soft system, 19 bits
  typedef struct packed {
    logic    de;
    logic    hs;
    logic    vs;
    rgb565_t pixel;
  } video_in_t;

  // pixel stream to the scaler, 27 bits
  typedef struct packed {
    logic    de;
    logic    hs;
    logic    vs;
    rgb888_t pixel;
  } video_out_t;

  // dataslot read request, 81 bits
  typedef struct packed {
    logic         read;
    bridge_data_t data_offset;
    bridge_data_t length;
    slot_id_t     slot_id;
  } slot_read_t;

endpackage

// File: src/core_glue_settings.svh
/*
 * core glue constants
 * widths, hold counts and bridge decode values shared by the
 * reset sequencer, dataslot bridge and video output blocks
 */

`ifndef CORE_GLUE_SETTINGS_SVH
`define CORE_GLUE_SETTINGS_SVH

//////////////////////////////////////////////////
// bridge bus and dataslot widths
//////////////////////////////////////////////////

// bridge address and data words
`define CORE_BRIDGE_W 32
// dataslot id from the soft system
`define CORE_SLOT_ID_W 16
// data table address toward the bridge command core
`define CORE_TABLE_ADDR_W 10

//////////////////////////////////////////////////
// timing constants
//////////////////////////////////////////////////

// reset countdown, hold length is all ones
`define CORE_RESET_TIMER_W 16
// read strobe length in cycles and its counter width
`define CORE_READ_STRETCH 7
`define CORE_READ_STRETCH_W 3
// depth of every input synchronizer
`define CORE_SYNC_STAGES 3
// upper address byte of the command region
`define CORE_CMD_REGION 8'hF8

`endif
